// File: compile.f
+incdir+hdl
hdl/vdec_isa_pkg.sv
hdl/vdec_ctrl_pkg.sv
hdl/vdec_field_stage.sv
hdl/vdec_op_stage.sv
hdl/vdec_ctrl_stage.sv
hdl/vector_decode_top.sv
tb/tb_vector_decode.sv

// File: hdl/vdec_ctrl_pkg.sv
//**************************************************************************
// Decoded result types and the structs carried between decode stages.
// Struct layouts are packed; downstream users slice by member name only.
//**************************************************************************
`include "vdec_defs.svh"

package vdec_ctrl_pkg;

  typedef enum logic [5:0] {
    BAD_OP,
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM
  } vop_t;

  typedef enum logic [2:0] {ARITH, RED, MUL, DIV, LOAD_UNIT, STORE_UNIT} fu_type_t;

  typedef enum logic [3:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR,
    VALU_SLL, VALU_SRL, VALU_SRA, VALU_COMP, VALU_MM
  } valu_op_t;

  typedef enum logic [2:0] {VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT} comp_type_t;
  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_t;
  typedef enum logic [1:0] {UNSIGNED, SIGNED, UNSIGNED_SIGNED} sign_t;
  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfg_sel_t;
  typedef enum logic [1:0] {V, X, I} operand_src_t;

  // stage 1 output, raw fields plus coarse class
  typedef struct packed {
    vdec_isa_pkg::opcode_t  opcode;
    vdec_isa_pkg::vfunct3_t funct3;
    logic [5:0]             funct6;
    logic [`VDEC_REG_W-1:0] vs1;
    logic [`VDEC_REG_W-1:0] vs2;
    logic [`VDEC_REG_W-1:0] vd;
    logic                   vm;
    vdec_isa_pkg::mop_t     mop;
    vdec_isa_pkg::width_t   mem_width;
    logic                   is_load;
    logic                   is_store;
    logic                   is_vopi;
    logic                   is_vopm;
    cfg_sel_t               cfg_sel;
  } vdec_fields_t;

  // stage 2 output
  typedef struct packed {
    vdec_fields_t fields;
    vop_t         vop;
    logic         illegal;
  } vdec_op_t;

  // final control word
  typedef struct packed {
    vop_t                   vop;
    fu_type_t               fu_type;
    valu_op_t               aluop;
    comp_type_t             comp_type;
    minmax_t                minmax_type;
    sign_t                  is_signed;
    cfg_sel_t               cfg_sel;
    operand_src_t           rs1_type;
    operand_src_t           rs2_type;
    logic [1:0]             stride_type;
    logic [1:0]             wen;
    logic                   dren;
    logic                   dwen;
    logic                   illegal;
    logic                   de_en;
    logic [`VDEC_REG_W-1:0] vd;
    logic [`VDEC_REG_W-1:0] vs1;
    logic [`VDEC_REG_W-1:0] vs2;
  } vdec_ctrl_t;

endpackage

// File: hdl/vdec_ctrl_stage.sv
//**************************************************************************
// Decode stage 3. Expands the operation code into the control word.
// Loads and stores carry BAD_OP from stage 2 but are not flagged illegal.
//**************************************************************************
`timescale 1ns/1ps

module vdec_ctrl_stage
  import vdec_isa_pkg::*;
  import vdec_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       o_valid,
  input  vdec_op_t   op,
  output logic       ctrl_valid,
  output vdec_ctrl_t ctrl
);

  vdec_ctrl_t ctrl_d;
  logic       is_mem;
  logic       vec_op;
  logic       strided;

  assign is_mem  = op.fields.is_load || op.fields.is_store;
  assign vec_op  = op.fields.opcode == VECTOR;
  assign strided = is_mem && (op.fields.mop == MOP_STRIDED);

  always_comb begin
    ctrl_d.vop     = op.vop;
    ctrl_d.cfg_sel = op.fields.cfg_sel;
    ctrl_d.vd      = op.fields.vd;
    ctrl_d.vs1     = op.fields.vs1;
    ctrl_d.vs2     = op.fields.vs2;
    ctrl_d.dren    = op.fields.is_load;
    ctrl_d.dwen    = op.fields.is_store;
    // memory ops are decoded by the load/store path, not the vector op map
    ctrl_d.illegal = op.illegal && !is_mem;
    ctrl_d.de_en   = vec_op && !op.illegal && (op.fields.cfg_sel == NOT_CFG);

    // unit select, illegal and config fall through to ARITH
    if (op.fields.is_load) begin
      ctrl_d.fu_type = LOAD_UNIT;
    end else if (op.fields.is_store) begin
      ctrl_d.fu_type = STORE_UNIT;
    end else begin
      case (op.vop)
        OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
        OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: ctrl_d.fu_type = RED;
        OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU:         ctrl_d.fu_type = MUL;
        OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:             ctrl_d.fu_type = DIV;
        default:                                          ctrl_d.fu_type = ARITH;
      endcase
    end

    case (op.vop)
      OP_VADD, OP_VREDSUM:                  ctrl_d.aluop = VALU_ADD;
      OP_VSUB, OP_VRSUB:                    ctrl_d.aluop = VALU_SUB;
      OP_VAND, OP_VREDAND:                  ctrl_d.aluop = VALU_AND;
      OP_VOR, OP_VREDOR:                    ctrl_d.aluop = VALU_OR;
      OP_VXOR, OP_VREDXOR:                  ctrl_d.aluop = VALU_XOR;
      OP_VSRL:                              ctrl_d.aluop = VALU_SRL;
      OP_VSRA:                              ctrl_d.aluop = VALU_SRA;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: ctrl_d.aluop = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: ctrl_d.aluop = VALU_MM;
      default:                              ctrl_d.aluop = VALU_SLL;
    endcase

    case (op.vop)
      OP_VMSNE:  ctrl_d.comp_type = VSNE;
      OP_VMSLTU: ctrl_d.comp_type = VSLTU;
      OP_VMSLT:  ctrl_d.comp_type = VSLT;
      OP_VMSLEU: ctrl_d.comp_type = VSLEU;
      OP_VMSLE:  ctrl_d.comp_type = VSLE;
      OP_VMSGTU: ctrl_d.comp_type = VSGTU;
      OP_VMSGT:  ctrl_d.comp_type = VSGT;
      default:   ctrl_d.comp_type = VSEQ;
    endcase

    case (op.vop)
      OP_VMINU, OP_VREDMINU: ctrl_d.minmax_type = MINU;
      OP_VMAX, OP_VREDMAX:   ctrl_d.minmax_type = MAX;
      OP_VMAXU, OP_VREDMAXU: ctrl_d.minmax_type = MAXU;
      default:               ctrl_d.minmax_type = MIN;
    endcase

    case (op.vop)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ, OP_VMSNE,
      OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM, OP_VREDMIN, OP_VREDMAX,
      OP_VMUL, OP_VMULH, OP_VDIV, OP_VREM: ctrl_d.is_signed = SIGNED;
      // vs2 signed, vs1 unsigned
      OP_VMULHSU:                          ctrl_d.is_signed = UNSIGNED_SIGNED;
      default:                             ctrl_d.is_signed = UNSIGNED;
    endcase

    // scalar rs1 for memory base, .vx forms and vsetvl(i) avl
    if (is_mem || (vec_op && (op.fields.funct3 inside {OPIVX, OPMVX})) ||
        (op.fields.cfg_sel inside {VSETVLI, VSETVL})) begin
      ctrl_d.rs1_type = X;
    end else if (vec_op && (op.fields.funct3 inside {OPIVI, OPCFG})) begin
      ctrl_d.rs1_type = I;
    end else begin
      ctrl_d.rs1_type = V;
    end

    ctrl_d.stride_type = strided ? 2'd1 : 2'd0;
    ctrl_d.rs2_type    = strided ? X : V;

    if (op.fields.is_load || ((op.fields.is_vopi || op.fields.is_vopm) && !op.illegal)) begin
      ctrl_d.wen = 2'b11;
    end else begin
      ctrl_d.wen = 2'b00;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_valid <= 1'b0;
    end else begin
      ctrl_valid <= o_valid;
    end
  end

  always_ff @(posedge clk) begin
    ctrl <= ctrl_d;
  end

  a_dren_dwen_excl: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> !(ctrl.dren && ctrl.dwen));

endmodule

// File: hdl/vdec_defs.svh
//**************************************************************************
// Widths and instruction field positions for the vector decoder.
// Field positions follow the RVV 1.0 OP-V and LOAD-FP/STORE-FP layouts.
// vd, vs1 and vs2 positions are derived from these macros.
//**************************************************************************
`ifndef VDEC_DEFS_SVH
`define VDEC_DEFS_SVH

`define VDEC_INSTR_W     32
`define VDEC_REG_W       5
// registered stages between instr and ctrl
`define VDEC_PIPE_DEPTH  3

// bit positions inside the instruction word
`define VDEC_OPCODE_MSB  6
`define VDEC_FUNCT3_LSB  12
`define VDEC_FUNCT6_LSB  26
`define VDEC_VM_BIT      25
`define VDEC_MOP_LSB     26

`endif

// File: hdl/vdec_field_stage.sv
//**************************************************************************
// Decode stage 1. Slices the instruction and classifies it, one cycle.
// Loads and stores are only recognised at widths 8, 16 and 32.
//**************************************************************************
`timescale 1ns/1ps
`include "vdec_defs.svh"

module vdec_field_stage
  import vdec_isa_pkg::*;
  import vdec_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     instr_valid,
  input  logic [`VDEC_INSTR_W-1:0] instr,
  output logic                     f_valid,
  output vdec_fields_t             fields
);

  vdec_fields_t fields_d;
  opcode_t      opcode;
  vfunct3_t     funct3;
  logic         width_ok;

  assign opcode   = opcode_t'(instr[`VDEC_OPCODE_MSB:0]);
  assign funct3   = vfunct3_t'(instr[`VDEC_FUNCT3_LSB +: 3]);
  // memory width shares the funct3 slot
  assign width_ok = width_t'(funct3) inside {WIDTH8, WIDTH16, WIDTH32};

  always_comb begin
    fields_d.opcode    = opcode;
    fields_d.funct3    = funct3;
    fields_d.funct6    = instr[`VDEC_FUNCT6_LSB +: 6];
    fields_d.vd        = instr[`VDEC_OPCODE_MSB+1 +: `VDEC_REG_W];
    fields_d.vs1       = instr[`VDEC_FUNCT3_LSB+3 +: `VDEC_REG_W];
    fields_d.vs2       = instr[`VDEC_VM_BIT-`VDEC_REG_W +: `VDEC_REG_W];
    fields_d.vm        = instr[`VDEC_VM_BIT];
    fields_d.mop       = mop_t'(instr[`VDEC_MOP_LSB +: 2]);
    fields_d.mem_width = width_t'(funct3);
    fields_d.is_load   = (opcode == LOAD_FP) && width_ok;
    fields_d.is_store  = (opcode == STORE_FP) && width_ok;
    fields_d.is_vopi   = (opcode == VECTOR) && (funct3 inside {OPIVV, OPIVI, OPIVX});
    fields_d.is_vopm   = (opcode == VECTOR) && (funct3 inside {OPMVV, OPMVX});

    // vsetvli 0x, vsetivli 11, vsetvl 10 in bits 31:30
    fields_d.cfg_sel = NOT_CFG;
    if ((opcode == VECTOR) && (funct3 == OPCFG)) begin
      if (!instr[`VDEC_INSTR_W-1]) begin
        fields_d.cfg_sel = VSETVLI;
      end else if (instr[`VDEC_INSTR_W-2]) begin
        fields_d.cfg_sel = VSETIVLI;
      end else begin
        fields_d.cfg_sel = VSETVL;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      f_valid <= 1'b0;
    end else begin
      f_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    fields <= fields_d;
  end

  // one opcode can never be both memory directions
  a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n)
    f_valid |-> !(fields.is_load && fields.is_store));

endmodule

// File: hdl/vdec_isa_pkg.sv
//**************************************************************************
// Raw instruction encodings, values as in RVV 1.0.
// Only the integer OPI/OPM subset handled by the decoder is listed.
//**************************************************************************
package vdec_isa_pkg;

  typedef enum logic [6:0] {
    LOAD_FP  = 7'h07,
    STORE_FP = 7'h27,
    VECTOR   = 7'h57
  } opcode_t;

  typedef enum logic [2:0] {
    OPIVV = 3'd0,
    OPFVV = 3'd1,
    OPMVV = 3'd2,
    OPIVI = 3'd3,
    OPIVX = 3'd4,
    OPFVF = 3'd5,
    OPMVX = 3'd6,
    OPCFG = 3'd7
  } vfunct3_t;

  // funct6 under OPIVV/OPIVX/OPIVI
  typedef enum logic [5:0] {
    VADD   = 6'b000000, VSUB   = 6'b000010, VRSUB  = 6'b000011,
    VMINU  = 6'b000100, VMIN   = 6'b000101, VMAXU  = 6'b000110,
    VMAX   = 6'b000111, VAND   = 6'b001001, VOR    = 6'b001010,
    VXOR   = 6'b001011, VMSEQ  = 6'b011000, VMSNE  = 6'b011001,
    VMSLTU = 6'b011010, VMSLT  = 6'b011011, VMSLEU = 6'b011100,
    VMSLE  = 6'b011101, VMSGTU = 6'b011110, VMSGT  = 6'b011111,
    VSLL   = 6'b100101, VSRL   = 6'b101000, VSRA   = 6'b101001
  } vopi_t;

  // funct6 under OPMVV/OPMVX
  typedef enum logic [5:0] {
    VREDSUM  = 6'b000000, VREDAND  = 6'b000001, VREDOR   = 6'b000010,
    VREDXOR  = 6'b000011, VREDMINU = 6'b000100, VREDMIN  = 6'b000101,
    VREDMAXU = 6'b000110, VREDMAX  = 6'b000111, VDIVU    = 6'b100000,
    VDIV     = 6'b100001, VREMU    = 6'b100010, VREM     = 6'b100011,
    VMULHU   = 6'b100100, VMUL     = 6'b100101, VMULHSU  = 6'b100110,
    VMULH    = 6'b100111
  } vopm_t;

  // element width of vector loads and stores
  typedef enum logic [2:0] {
    WIDTH8  = 3'd0,
    WIDTH16 = 3'd5,
    WIDTH32 = 3'd6
  } width_t;

  typedef enum logic [1:0] {
    MOP_UNIT    = 2'd0,
    MOP_STRIDED = 2'd2
  } mop_t;

endpackage

// File: hdl/vdec_op_stage.sv
//**************************************************************************
// Decode stage 2. Maps funct6 and funct3 to a single operation code.
// Anything outside the kept OPI/OPM subset comes out as BAD_OP/illegal,
// which includes loads, stores and config instructions at this point.
//**************************************************************************
`timescale 1ns/1ps

module vdec_op_stage
  import vdec_isa_pkg::*;
  import vdec_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         f_valid,
  input  vdec_fields_t fields,
  output logic         o_valid,
  output vdec_op_t     op
);

  vopi_t    opi_code;
  vopm_t    opm_code;
  logic     form_vvx;
  logic     form_vxi;
  logic     form_mvv;
  vop_t     vop_d;
  vdec_op_t op_d;

  assign opi_code = vopi_t'(fields.funct6);
  assign opm_code = vopm_t'(fields.funct6);

  // operand forms each operation accepts
  assign form_vvx  = fields.funct3 inside {OPIVV, OPIVX};
  assign form_vxi  = fields.funct3 inside {OPIVX, OPIVI};
  assign form_mvv  = fields.funct3 == OPMVV;

  always_comb begin
    vop_d = BAD_OP;
    if (fields.is_vopi) begin
      // is_vopi already limits funct3 to VV/VX/VI, so all-form ops need no check
      case (opi_code)
        VADD:    vop_d = OP_VADD;
        VSUB:    vop_d = form_vvx  ? OP_VSUB   : BAD_OP;
        VRSUB:   vop_d = form_vxi  ? OP_VRSUB  : BAD_OP;
        VMINU:   vop_d = form_vvx  ? OP_VMINU  : BAD_OP;
        VMIN:    vop_d = form_vvx  ? OP_VMIN   : BAD_OP;
        VMAXU:   vop_d = form_vvx  ? OP_VMAXU  : BAD_OP;
        VMAX:    vop_d = form_vvx  ? OP_VMAX   : BAD_OP;
        VAND:    vop_d = OP_VAND;
        VOR:     vop_d = OP_VOR;
        VXOR:    vop_d = OP_VXOR;
        VMSEQ:   vop_d = OP_VMSEQ;
        VMSNE:   vop_d = OP_VMSNE;
        VMSLTU:  vop_d = form_vvx  ? OP_VMSLTU : BAD_OP;
        VMSLT:   vop_d = form_vvx  ? OP_VMSLT  : BAD_OP;
        VMSLEU:  vop_d = OP_VMSLEU;
        VMSLE:   vop_d = OP_VMSLE;
        VMSGTU:  vop_d = form_vxi  ? OP_VMSGTU : BAD_OP;
        VMSGT:   vop_d = form_vxi  ? OP_VMSGT  : BAD_OP;
        VSLL:    vop_d = OP_VSLL;
        VSRL:    vop_d = OP_VSRL;
        VSRA:    vop_d = OP_VSRA;
        default: vop_d = BAD_OP;
      endcase
    end else if (fields.is_vopm) begin
      // is_vopm already limits funct3 to MVV/MVX, so mul and div need no form check
      case (opm_code)
        VREDSUM:  vop_d = form_mvv ? OP_VREDSUM  : BAD_OP;
        VREDAND:  vop_d = form_mvv ? OP_VREDAND  : BAD_OP;
        VREDOR:   vop_d = form_mvv ? OP_VREDOR   : BAD_OP;
        VREDXOR:  vop_d = form_mvv ? OP_VREDXOR  : BAD_OP;
        VREDMINU: vop_d = form_mvv ? OP_VREDMINU : BAD_OP;
        VREDMIN:  vop_d = form_mvv ? OP_VREDMIN  : BAD_OP;
        VREDMAXU: vop_d = form_mvv ? OP_VREDMAXU : BAD_OP;
        VREDMAX:  vop_d = form_mvv ? OP_VREDMAX  : BAD_OP;
        VMUL:     vop_d = OP_VMUL;
        VMULH:    vop_d = OP_VMULH;
        VMULHU:   vop_d = OP_VMULHU;
        VMULHSU:  vop_d = OP_VMULHSU;
        VDIVU:    vop_d = OP_VDIVU;
        VDIV:     vop_d = OP_VDIV;
        VREMU:    vop_d = OP_VREMU;
        VREM:     vop_d = OP_VREM;
        default:  vop_d = BAD_OP;
      endcase
    end
  end

  always_comb begin
    op_d.fields  = fields;
    op_d.vop     = vop_d;
    op_d.illegal = (vop_d == BAD_OP);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= f_valid;
    end
  end

  always_ff @(posedge clk) begin
    op <= op_d;
  end

  // a legal op belongs to exactly one of the OPI and OPM classes
  a_legal_one_class: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !op.illegal |-> (op.fields.is_vopi != op.fields.is_vopm));

endmodule

// File: hdl/vector_decode_top.sv
//**************************************************************************
// Three-stage vector instruction decoder, no back-pressure.
// ctrl_valid follows instr_valid three clocks later, in order.
//**************************************************************************
`timescale 1ns/1ps
`include "vdec_defs.svh"

module vector_decode_top
  import vdec_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     instr_valid,
  input  logic [`VDEC_INSTR_W-1:0] instr,
  output logic                     ctrl_valid,
  output vdec_ctrl_t               ctrl
);

  logic         f_valid;
  vdec_fields_t fields;
  logic         o_valid;
  vdec_op_t     op;

  vdec_field_stage field_stage_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .f_valid     (f_valid),
    .fields      (fields)
  );

  vdec_op_stage op_stage_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .f_valid (f_valid),
    .fields  (fields),
    .o_valid (o_valid),
    .op      (op)
  );

  vdec_ctrl_stage ctrl_stage_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .o_valid    (o_valid),
    .op         (op),
    .ctrl_valid (ctrl_valid),
    .ctrl       (ctrl)
  );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the vector decoder testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_vector_decode -f compile.f -o tb_vector_decode

./obj_dir/tb_vector_decode > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation passed"

// File: tb/tb_vector_decode.sv
//**************************************************************************
// Self-checking testbench for the three-stage vector decoder.
// Expected control words come from reference functions over the raw
// instruction word, checked by concurrent assertions on ctrl_valid.
//**************************************************************************
`timescale 1ns/1ps
`include "vdec_defs.svh"

module tb_vector_decode
  import vdec_isa_pkg::*;
  import vdec_ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  // reset, idle, opi, opm, mem, cfg, gapped, random, drain
  localparam int STIM_CYCLES = 2 + 3 + 192 + 128 + 16 + 4 + 30 + 250 + 5;
  localparam logic [2:0] OPI_FORMS [3] = '{OPIVV, OPIVI, OPIVX};
  localparam logic [2:0] OPM_FORMS [2] = '{OPMVV, OPMVX};
  // last one is not a kept width
  localparam logic [2:0] MEM_WIDTHS [4] = '{3'd0, 3'd5, 3'd6, 3'd7};

  logic                     clk;
  logic                     rst_n;
  logic                     instr_valid;
  logic [`VDEC_INSTR_W-1:0] instr;
  logic                     ctrl_valid;
  vdec_ctrl_t               ctrl;

  logic [`VDEC_INSTR_W-1:0]   hist_instr [`VDEC_PIPE_DEPTH];
  logic [`VDEC_PIPE_DEPTH-1:0] hist_valid;
  vdec_ctrl_t                 exp_ctrl;
  logic                       chk_alu;
  int                         errors;
  int                         issued;

  vector_decode_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ctrl_valid  (ctrl_valid),
    .ctrl        (ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // operation from funct6 and the operand forms each one allows
  function automatic vop_t ref_vop(input logic [31:0] ins);
    logic [5:0] f6;
    logic [2:0] f3;
    logic       vv;
    logic       vx;
    logic       vi;
    logic       mvv;
    logic       mvx;
    vop_t       r;
    f6  = ins[31:26];
    f3  = ins[14:12];
    vv  = (ins[6:0] == VECTOR) && (f3 == 3'd0);
    vi  = (ins[6:0] == VECTOR) && (f3 == 3'd3);
    vx  = (ins[6:0] == VECTOR) && (f3 == 3'd4);
    mvv = (ins[6:0] == VECTOR) && (f3 == 3'd2);
    mvx = (ins[6:0] == VECTOR) && (f3 == 3'd6);
    r   = BAD_OP;
    if (vv || vx || vi) begin
      case (f6)
        VADD:    r = OP_VADD;
        VSUB:    r = vi ? BAD_OP : OP_VSUB;
        VRSUB:   r = vv ? BAD_OP : OP_VRSUB;
        VMINU:   r = vi ? BAD_OP : OP_VMINU;
        VMIN:    r = vi ? BAD_OP : OP_VMIN;
        VMAXU:   r = vi ? BAD_OP : OP_VMAXU;
        VMAX:    r = vi ? BAD_OP : OP_VMAX;
        VAND:    r = OP_VAND;
        VOR:     r = OP_VOR;
        VXOR:    r = OP_VXOR;
        VMSEQ:   r = OP_VMSEQ;
        VMSNE:   r = OP_VMSNE;
        VMSLTU:  r = vi ? BAD_OP : OP_VMSLTU;
        VMSLT:   r = vi ? BAD_OP : OP_VMSLT;
        VMSLEU:  r = OP_VMSLEU;
        VMSLE:   r = OP_VMSLE;
        VMSGTU:  r = vv ? BAD_OP : OP_VMSGTU;
        VMSGT:   r = vv ? BAD_OP : OP_VMSGT;
        VSLL:    r = OP_VSLL;
        VSRL:    r = OP_VSRL;
        VSRA:    r = OP_VSRA;
        default: r = BAD_OP;
      endcase
    end else if (mvv || mvx) begin
      case (f6)
        VREDSUM:  r = mvv ? OP_VREDSUM : BAD_OP;
        VREDAND:  r = mvv ? OP_VREDAND : BAD_OP;
        VREDOR:   r = mvv ? OP_VREDOR : BAD_OP;
        VREDXOR:  r = mvv ? OP_VREDXOR : BAD_OP;
        VREDMINU: r = mvv ? OP_VREDMINU : BAD_OP;
        VREDMIN:  r = mvv ? OP_VREDMIN : BAD_OP;
        VREDMAXU: r = mvv ? OP_VREDMAXU : BAD_OP;
        VREDMAX:  r = mvv ? OP_VREDMAX : BAD_OP;
        VMUL:     r = OP_VMUL;
        VMULH:    r = OP_VMULH;
        VMULHU:   r = OP_VMULHU;
        VMULHSU:  r = OP_VMULHSU;
        VDIVU:    r = OP_VDIVU;
        VDIV:     r = OP_VDIV;
        VREMU:    r = OP_VREMU;
        VREM:     r = OP_VREM;
        default:  r = BAD_OP;
      endcase
    end
    return r;
  endfunction

  // full expected control word for one instruction
  function automatic vdec_ctrl_t ref_ctrl(input logic [31:0] ins);
    vdec_ctrl_t c;
    logic [2:0] f3;
    logic       vec;
    logic       ld;
    logic       st;
    logic       strided;
    logic       legal;
    f3      = ins[14:12];
    vec     = ins[6:0] == VECTOR;
    ld      = (ins[6:0] == LOAD_FP) && (f3 inside {3'd0, 3'd5, 3'd6});
    st      = (ins[6:0] == STORE_FP) && (f3 inside {3'd0, 3'd5, 3'd6});
    strided = (ld || st) && (ins[27:26] == 2'b10);
    c.vop   = ref_vop(ins);
    legal   = c.vop != BAD_OP;

    c.cfg_sel = NOT_CFG;
    if (vec && (f3 == 3'd7)) begin
      c.cfg_sel = !ins[31] ? VSETVLI : (ins[30] ? VSETIVLI : VSETVL);
    end
    c.illegal     = !legal && !(ld || st);
    c.de_en       = legal;
    c.dren        = ld;
    c.dwen        = st;
    c.wen         = (ld || legal) ? 2'b11 : 2'b00;
    c.stride_type = strided ? 2'd1 : 2'd0;
    c.rs2_type    = strided ? X : V;
    c.vd          = ins[11:7];
    c.vs1         = ins[19:15];
    c.vs2         = ins[24:20];

    if (ld || st || (vec && (f3 inside {3'd4, 3'd6})) || (c.cfg_sel inside {VSETVLI, VSETVL})) begin
      c.rs1_type = X;
    end else if (vec && (f3 inside {3'd3, 3'd7})) begin
      c.rs1_type = I;
    end else begin
      c.rs1_type = V;
    end

    c.fu_type     = ld ? LOAD_UNIT : (st ? STORE_UNIT : ARITH);
    c.aluop       = VALU_ADD;
    c.comp_type   = VSEQ;
    c.minmax_type = MIN;
    c.is_signed   = UNSIGNED;
    case (c.vop)
      OP_VADD, OP_VREDSUM:   c.aluop = VALU_ADD;
      OP_VSUB, OP_VRSUB:     c.aluop = VALU_SUB;
      OP_VAND, OP_VREDAND:   c.aluop = VALU_AND;
      OP_VOR, OP_VREDOR:     c.aluop = VALU_OR;
      OP_VXOR, OP_VREDXOR:   c.aluop = VALU_XOR;
      OP_VSLL:               c.aluop = VALU_SLL;
      OP_VSRL:               c.aluop = VALU_SRL;
      OP_VSRA:               c.aluop = VALU_SRA;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: c.aluop = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: c.aluop = VALU_MM;
      default:               c.aluop = VALU_ADD;
    endcase
    case (c.vop)
      OP_VMSNE:  c.comp_type = VSNE;
      OP_VMSLTU: c.comp_type = VSLTU;
      OP_VMSLT:  c.comp_type = VSLT;
      OP_VMSLEU: c.comp_type = VSLEU;
      OP_VMSLE:  c.comp_type = VSLE;
      OP_VMSGTU: c.comp_type = VSGTU;
      OP_VMSGT:  c.comp_type = VSGT;
      default:   c.comp_type = VSEQ;
    endcase
    case (c.vop)
      OP_VMINU, OP_VREDMINU: c.minmax_type = MINU;
      OP_VMAX, OP_VREDMAX:   c.minmax_type = MAX;
      OP_VMAXU, OP_VREDMAXU: c.minmax_type = MAXU;
      default:               c.minmax_type = MIN;
    endcase
    case (c.vop)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ, OP_VMSNE,
      OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM, OP_VREDMIN, OP_VREDMAX,
      OP_VMUL, OP_VMULH, OP_VDIV, OP_VREM: c.is_signed = SIGNED;
      OP_VMULHSU:                          c.is_signed = UNSIGNED_SIGNED;
      default:                             c.is_signed = UNSIGNED;
    endcase
    case (c.vop)
      OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: c.fu_type = RED;
      OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU:         c.fu_type = MUL;
      OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:             c.fu_type = DIV;
      default: ;
    endcase
    return c;
  endfunction

  function automatic logic [31:0] make_opv(input logic [5:0] f6, input logic [2:0] f3);
    logic [31:0] rnd;
    rnd = $urandom;
    return {f6, rnd[25:15], f3, rnd[11:7], VECTOR};
  endfunction

  function automatic logic [31:0] make_mem(input logic [6:0] opc, input logic [2:0] width,
                                           input logic [1:0] mop);
    logic [31:0] rnd;
    rnd = $urandom;
    // nf and mew stay zero
    return {4'b0000, mop, rnd[25:15], width, rnd[11:7], opc};
  endfunction

  function automatic logic [31:0] make_cfg(input logic [1:0] top_bits);
    logic [31:0] rnd;
    rnd = $urandom;
    return {top_bits, rnd[29:15], 3'b111, rnd[11:7], VECTOR};
  endfunction

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic issue(input logic [31:0] ins);
    @(posedge clk);
    #1;
    instr_valid = 1'b1;
    instr       = ins;
    issued++;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    instr       = $urandom;
  endtask

  // instruction history, aligned with the three decode stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hist_valid <= '0;
    end else begin
      hist_valid <= {hist_valid[`VDEC_PIPE_DEPTH-2:0], instr_valid};
    end
  end

  always_ff @(posedge clk) begin
    hist_instr[0] <= instr;
    for (int i = 1; i < `VDEC_PIPE_DEPTH; i++) begin
      hist_instr[i] <= hist_instr[i-1];
    end
  end

  always_comb begin
    exp_ctrl = ref_ctrl(hist_instr[`VDEC_PIPE_DEPTH-1]);
    chk_alu  = (exp_ctrl.fu_type inside {ARITH, RED}) && (exp_ctrl.vop != BAD_OP);
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !ctrl_valid)
    else flag_mismatch("ctrl_valid high while in reset");
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid == hist_valid[`VDEC_PIPE_DEPTH-1])
    else flag_mismatch("ctrl_valid does not follow instr_valid by three cycles");
  a_vop: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> (ctrl.vop == exp_ctrl.vop))
    else flag_mismatch("decoded vop differs from reference");
  a_fu_type: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> (ctrl.fu_type == exp_ctrl.fu_type))
    else flag_mismatch("fu_type differs from reference");
  a_legality: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> (ctrl.illegal == exp_ctrl.illegal) && (ctrl.de_en == exp_ctrl.de_en))
    else flag_mismatch("illegal or de_en differs from reference");
  a_aluop: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid && chk_alu |-> (ctrl.aluop == exp_ctrl.aluop))
    else flag_mismatch("aluop differs from reference");
  a_comp_type: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid && chk_alu && (exp_ctrl.aluop == VALU_COMP) |->
    (ctrl.comp_type == exp_ctrl.comp_type))
    else flag_mismatch("comp_type differs from reference");
  a_minmax: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid && chk_alu && (exp_ctrl.aluop == VALU_MM) |->
    (ctrl.minmax_type == exp_ctrl.minmax_type))
    else flag_mismatch("minmax_type differs from reference");
  a_signed: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> (ctrl.is_signed == exp_ctrl.is_signed))
    else flag_mismatch("is_signed differs from reference");
  a_operands: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> (ctrl.cfg_sel == exp_ctrl.cfg_sel) && (ctrl.rs1_type == exp_ctrl.rs1_type) &&
    (ctrl.rs2_type == exp_ctrl.rs2_type) && (ctrl.stride_type == exp_ctrl.stride_type))
    else flag_mismatch("cfg_sel, operand source or stride differs from reference");
  a_enables: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> (ctrl.wen == exp_ctrl.wen) && (ctrl.dren == exp_ctrl.dren) &&
    (ctrl.dwen == exp_ctrl.dwen))
    else flag_mismatch("wen, dren or dwen differs from reference");
  a_reg_fields: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid |-> (ctrl.vd == exp_ctrl.vd) && (ctrl.vs1 == exp_ctrl.vs1) &&
    (ctrl.vs2 == exp_ctrl.vs2))
    else flag_mismatch("register specifiers differ from the instruction");
  a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_valid && ctrl.illegal |-> (ctrl.fu_type == ARITH) && (ctrl.wen == 2'b00) && !ctrl.de_en)
    else flag_mismatch("illegal instruction still enables a unit or a write");

  initial begin
    logic [31:0] word;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    errors      = 0;
    issued      = 0;
    void'($urandom(32'h950c));

    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) idle_cycle();

    // every funct6 in every OPI and OPM form, back to back
    for (int f6 = 0; f6 < 64; f6++) begin
      foreach (OPI_FORMS[k]) issue(make_opv(6'(f6), OPI_FORMS[k]));
    end
    for (int f6 = 0; f6 < 64; f6++) begin
      foreach (OPM_FORMS[k]) issue(make_opv(6'(f6), OPM_FORMS[k]));
    end

    for (int o = 0; o < 2; o++) begin
      foreach (MEM_WIDTHS[w]) begin
        issue(make_mem(o ? STORE_FP : LOAD_FP, MEM_WIDTHS[w], MOP_UNIT));
        issue(make_mem(o ? STORE_FP : LOAD_FP, MEM_WIDTHS[w], MOP_STRIDED));
      end
    end

    issue(make_cfg(2'b00));
    issue(make_cfg(2'b01));
    issue(make_cfg(2'b11));
    issue(make_cfg(2'b10));

    // gaps of zero to two idle cycles
    for (int n = 0; n < 10; n++) begin
      issue(make_opv(6'($urandom), 3'($urandom)));
      repeat ($urandom_range(2)) idle_cycle();
    end

    for (int n = 0; n < 250; n++) begin
      word = $urandom;
      if ($urandom_range(1) == 1) begin
        word[6:0] = VECTOR;
      end
      if ($urandom_range(3) != 0) begin
        issue(word);
      end else begin
        idle_cycle();
      end
    end

    repeat (5) idle_cycle();

    $display("decoder run: %0d instructions issued, %0d checks failed", issued, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #((STIM_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: stimulus did not finish within %0d clock cycles", STIM_CYCLES + 20);
    $display("Test failed");
    $finish;
  end

endmodule
